// File: Makefile
# Verilator build and run for the TCP receive demultiplexer

TOP := tcp_rx_arbiter_tb
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		-f src.f --top-module $(TOP) -Mdir $(OBJ) -o $(TOP)

# The log decides pass or fail, not the simulator exit code
run: compile
	./$(OBJ)/$(TOP) | tee sim.log
	grep -q "^TEST OK$$" sim.log

clean:
	rm -rf $(OBJ) sim.log

// File: src.f
verilog/tcp_rx_pkg.sv
verilog/stream_fifo.sv
verilog/tcp_rx_meta_demux.sv
verilog/tcp_rx_data_demux.sv
verilog/tcp_rx_arbiter.sv
tb/tcp_rx_arbiter_checker.sv
tb/tcp_rx_arbiter_tb.sv

// File: tb/tcp_rx_arbiter_checker.sv
`default_nettype none

module tcp_rx_arbiter_checker import tcp_rx_pkg::*; (
  input logic                 aclk,
  input logic                 aresetn,
  input logic                 s_meta_valid,
  input logic                 s_meta_ready,
  input rx_meta_t             s_meta,
  input logic                 s_data_ready,
  input logic [N_REGIONS-1:0] m_req_valid,
  input logic [N_REGIONS-1:0] m_data_valid,
  // Last beat of the loaded payload accepted
  input logic                 payload_done
);

  // Payloads with metadata in and last beat not yet through
  int pending;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      pending <= 0;
    end else begin
      pending <= pending + int'(s_meta_valid && s_meta_ready) - int'(payload_done);
    end
  end

  // ------------------------------
  // Steering
  // ------------------------------

  // One FIFO written per cycle, so one valid can rise at a time
  assert property (@(posedge aclk) disable iff (!aresetn)
    $onehot0(m_data_valid & ~$past(m_data_valid)))
    else $error("Two region data valids rose in one cycle");

  // Beats only flow while some accepted payload is unfinished
  assert property (@(posedge aclk) disable iff (!aresetn)
    s_data_ready |-> (pending != 0))
    else $error("s_data ready high with no region selected");

  // ------------------------------
  // Handshake
  // ------------------------------

  assert property (@(posedge aclk) disable iff (!aresetn)
    (s_meta_valid && !s_meta_ready) |=> (s_meta_valid && $stable(s_meta)))
    else $error("s_meta changed or dropped while stalled");

  // Reset is synchronous, outputs clear one edge later
  assert property (@(posedge aclk)
    !aresetn |=> ((m_req_valid == '0) && (m_data_valid == '0) && !s_data_ready))
    else $error("Output valid high right after reset");

endmodule

bind tcp_rx_arbiter tcp_rx_arbiter_checker chk0 (
  .aclk         (aclk),
  .aresetn      (aresetn),
  .s_meta_valid (s_meta_valid),
  .s_meta_ready (s_meta_ready),
  .s_meta       (s_meta),
  .s_data_ready (s_data_ready),
  .m_req_valid  (m_req_valid),
  .m_data_valid (m_data_valid),
  .payload_done (data_demux.tr_done)
);

`default_nettype wire

// File: tb/tcp_rx_arbiter_tb.sv
`default_nettype none

module tcp_rx_arbiter_tb import tcp_rx_pkg::*; ();

  // ------------------------------
  // Run constants
  // ------------------------------

  localparam int CLK_PERIOD   = 4;
  localparam int SEED         = 76;
  localparam int N_PAYLOADS   = 200;
  // Upper bound on beats per payload, stall margin
  localparam int MAX_BEATS    = 13;
  localparam int STALL_FACTOR = 4;
  localparam int TIMEOUT      = N_PAYLOADS * MAX_BEATS * STALL_FACTOR * CLK_PERIOD;

  logic                 aclk = 1'b0;
  logic                 aresetn;
  logic                 s_meta_valid;
  logic                 s_meta_ready;
  rx_meta_t             s_meta;
  logic                 s_data_valid;
  logic                 s_data_ready;
  axis_beat_t           s_data;
  logic [N_REGIONS-1:0] m_req_valid;
  logic [N_REGIONS-1:0] m_req_ready;
  rx_req_t              m_req [N_REGIONS];
  logic [N_REGIONS-1:0] m_data_valid;
  logic [N_REGIONS-1:0] m_data_ready;
  axis_beat_t           m_data [N_REGIONS];
  logic [N_REGIONS-1:0] wr_rdy;

  // Stimulus in issue order
  rx_meta_t   meta_q [$];
  axis_beat_t in_beat_q [$];
  // Region owning each input beat
  region_t    beat_region_q [$];
  // Per-region scoreboards
  rx_req_t    exp_req_q [N_REGIONS][$];
  axis_beat_t exp_beat_q [N_REGIONS][$];
  // Beats accepted and read per region
  int         in_cnt [N_REGIONS];
  int         out_cnt [N_REGIONS];
  bit         full_seen = 1'b0;

  tcp_rx_arbiter dut0 (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .s_meta_valid (s_meta_valid),
    .s_meta_ready (s_meta_ready),
    .s_meta       (s_meta),
    .s_data_valid (s_data_valid),
    .s_data_ready (s_data_ready),
    .s_data       (s_data),
    .m_req_valid  (m_req_valid),
    .m_req_ready  (m_req_ready),
    .m_req        (m_req),
    .m_data_valid (m_data_valid),
    .m_data_ready (m_data_ready),
    .m_data       (m_data),
    .wr_rdy       (wr_rdy)
  );

  always #(CLK_PERIOD / 2) aclk = ~aclk;

  // ------------------------------
  // Reference and compare helpers
  // ------------------------------

  // Index of the final beat, a partial beat counts whole
  function automatic int expected_last_idx(input len_t len);
    return (int'(len) + 7) / 8 - 1;
  endfunction

  // Region 1 then region 2 held off long enough to fill
  function automatic bit in_stall(input int cyc, input int region);
    return (region == 1 && cyc >= 300 && cyc < 700) ||
           (region == 2 && cyc >= 1200 && cyc < 1600);
  endfunction

  function automatic bit outputs_drained();
    for (int i = 0; i < N_REGIONS; i++) begin
      if (exp_req_q[i].size() != 0 || exp_beat_q[i].size() != 0) return 1'b0;
    end
    return beat_region_q.size() == 0;
  endfunction

  task automatic stop_with_failure();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic compare_req(input string name, input rx_req_t exp, input rx_req_t act);
    if (act !== exp) begin
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic compare_beat(input string name, input axis_beat_t exp, input axis_beat_t act);
    if (act !== exp) begin
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic compare_flags(input string name, input logic [N_REGIONS-1:0] exp,
                               input logic [N_REGIONS-1:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s expected %b actual %b", name, exp, act);
      stop_with_failure();
    end
  endtask

  // ------------------------------
  // Stimulus
  // ------------------------------

  task automatic build_payloads();
    rx_meta_t   m;
    rx_req_t    r;
    axis_beat_t b;
    axis_beat_t e;
    int         last;
    for (int p = 0; p < N_PAYLOADS; p++) begin
      m.vfid = region_t'($urandom_range(N_REGIONS - 1));
      m.pid  = 6'($urandom);
      m.dest = 4'($urandom);
      m.len  = len_t'($urandom_range(96, 1));
      meta_q.push_back(m);
      r.pid  = m.pid;
      r.dest = m.dest;
      r.len  = m.len;
      exp_req_q[m.vfid].push_back(r);
      last = expected_last_idx(m.len);
      for (int k = 0; k <= last; k++) begin
        b.tdata = {$urandom, $urandom};
        b.tkeep = 8'($urandom);
        // Input tlast is noise, output must ignore it
        b.tlast = 1'($urandom);
        e       = b;
        e.tlast = (k == last);
        in_beat_q.push_back(b);
        exp_beat_q[m.vfid].push_back(e);
        beat_region_q.push_back(m.vfid);
      end
    end
  endtask

  // Both drivers start and end on a falling edge
  task automatic drive_meta();
    foreach (meta_q[p]) begin
      while ($urandom_range(3) == 0) @(negedge aclk);
      s_meta       = meta_q[p];
      s_meta_valid = 1'b1;
      @(posedge aclk);
      while (!s_meta_ready) @(posedge aclk);
      @(negedge aclk);
      s_meta_valid = 1'b0;
    end
  endtask

  task automatic drive_data();
    foreach (in_beat_q[p]) begin
      while ($urandom_range(3) == 0) @(negedge aclk);
      s_data       = in_beat_q[p];
      s_data_valid = 1'b1;
      @(posedge aclk);
      while (!s_data_ready) @(posedge aclk);
      @(negedge aclk);
      s_data_valid = 1'b0;
    end
  endtask

  // Random sink back-pressure plus long stall phases
  initial begin : drive_sinks
    int cyc;
    cyc          = 0;
    m_req_ready  = '0;
    m_data_ready = '0;
    forever begin
      @(negedge aclk);
      cyc++;
      for (int i = 0; i < N_REGIONS; i++) begin
        m_req_ready[i]  = ($urandom_range(3) != 0);
        m_data_ready[i] = in_stall(cyc, i) ? 1'b0 : ($urandom_range(3) != 0);
      end
    end
  end

  // ------------------------------
  // Scoreboard
  // ------------------------------

  // Sampled at the edge, model counts lag by one transfer
  always @(posedge aclk) begin : compare_outputs
    logic [N_REGIONS-1:0] exp_rdy;
    region_t              r;
    if (aresetn) begin
      for (int i = 0; i < N_REGIONS; i++) begin
        exp_rdy[i] = (in_cnt[i] - out_cnt[i]) <= WR_THRS;
        if (in_cnt[i] - out_cnt[i] == DATA_DEPTH) full_seen = 1'b1;
      end
      compare_flags("wr_rdy", exp_rdy, wr_rdy);
      if (s_data_valid && s_data_ready) begin
        if (beat_region_q.size() == 0) begin
          $display("Input beat accepted beyond the issued payloads");
          stop_with_failure();
        end
        r = beat_region_q.pop_front();
        in_cnt[r]++;
      end
      for (int i = 0; i < N_REGIONS; i++) begin
        if (m_req_valid[i] && m_req_ready[i]) begin
          if (exp_req_q[i].size() == 0) begin
            $display("Request on region %0d with none expected", i);
            stop_with_failure();
          end
          compare_req($sformatf("m_req[%0d]", i), exp_req_q[i].pop_front(), m_req[i]);
        end
        if (m_data_valid[i] && m_data_ready[i]) begin
          if (exp_beat_q[i].size() == 0) begin
            $display("Beat on region %0d with none expected", i);
            stop_with_failure();
          end
          compare_beat($sformatf("m_data[%0d]", i), exp_beat_q[i].pop_front(), m_data[i]);
          out_cnt[i]++;
        end
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT);
    $display("Timeout after %0d time units with traffic still pending", TIMEOUT);
    stop_with_failure();
  end

  // ------------------------------
  // Main sequence
  // ------------------------------

  initial begin : run_test
    void'($urandom(SEED));
    aresetn      = 1'b0;
    s_meta_valid = 1'b0;
    s_meta       = '0;
    s_data_valid = 1'b0;
    s_data       = '0;
    for (int i = 0; i < N_REGIONS; i++) begin
      in_cnt[i]  = 0;
      out_cnt[i] = 0;
    end
    build_payloads();
    repeat (3) @(posedge aclk);
    @(negedge aclk);
    // Outputs idle straight out of reset
    compare_flags("reset m_req_valid", '0, m_req_valid);
    compare_flags("reset m_data_valid", '0, m_data_valid);
    compare_flags("reset wr_rdy", '1, wr_rdy);
    aresetn = 1'b1;
    fork
      drive_meta();
      drive_data();
    join
    while (!outputs_drained()) @(negedge aclk);
    if (full_seen) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("No region data FIFO reached full depth during the stall phases");
      stop_with_failure();
    end
  end

endmodule

`default_nettype wire

// File: verilog/stream_fifo.sv
`default_nettype none

module stream_fifo import tcp_rx_pkg::*; #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 8
) (
  input  logic             aclk,
  input  logic             aresetn,
  // Write side
  input  logic             s_valid,
  output logic             s_ready,
  input  logic [WIDTH-1:0] s_data,
  // Read side
  output logic             m_valid,
  input  logic             m_ready,
  output logic [WIDTH-1:0] m_data,
  // Occupancy
  output fill_t            fill
);

  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WIDTH-1:0]    mem [DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  fill_t               count;
  logic                push;
  logic                pop;

  // ------------------------------
  // Handshake
  // ------------------------------

  // Full blocks writes only
  assign s_ready = (count != fill_t'(DEPTH));
  assign m_valid = (count != '0);
  assign push    = s_valid && s_ready;
  assign pop     = m_valid && m_ready;

  // Head of queue straight from storage
  assign m_data  = mem[rd_ptr];
  assign fill    = count;

  // ------------------------------
  // Storage
  // ------------------------------

  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= s_data;
    end
  end

  // Pointers wrap at DEPTH
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/tcp_rx_arbiter.sv
`default_nettype none

module tcp_rx_arbiter import tcp_rx_pkg::*; (
  input  logic                 aclk,
  input  logic                 aresetn,
  // Metadata in
  input  logic                 s_meta_valid,
  output logic                 s_meta_ready,
  input  rx_meta_t             s_meta,
  // Payload in
  input  logic                 s_data_valid,
  output logic                 s_data_ready,
  input  axis_beat_t           s_data,
  // Per-region requests
  output logic [N_REGIONS-1:0] m_req_valid,
  input  logic [N_REGIONS-1:0] m_req_ready,
  output rx_req_t              m_req [N_REGIONS],
  // Per-region payload
  output logic [N_REGIONS-1:0] m_data_valid,
  input  logic [N_REGIONS-1:0] m_data_ready,
  output axis_beat_t           m_data [N_REGIONS],
  output logic [N_REGIONS-1:0] wr_rdy
);

  logic [N_REGIONS-1:0] req_valid;
  logic [N_REGIONS-1:0] req_ready;
  rx_req_t              req;
  logic                 seq_in_valid;
  logic                 seq_in_ready;
  seq_entry_t           seq_in;
  logic                 seq_out_valid;
  logic                 seq_out_ready;
  seq_entry_t           seq_out;

  // ------------------------------
  // Metadata path
  // ------------------------------

  tcp_rx_meta_demux meta_demux (
    .s_meta_valid (s_meta_valid),
    .s_meta_ready (s_meta_ready),
    .s_meta       (s_meta),
    .req_valid    (req_valid),
    .req_ready    (req_ready),
    .req          (req),
    .seq_valid    (seq_in_valid),
    .seq_ready    (seq_in_ready),
    .seq          (seq_in)
  );

  // One request queue per region
  for (genvar i = 0; i < N_REGIONS; i++) begin : g_req_fifo
    stream_fifo #(
      .WIDTH($bits(rx_req_t)),
      .DEPTH(META_DEPTH)
    ) req_fifo (
      .aclk    (aclk),
      .aresetn (aresetn),
      .s_valid (req_valid[i]),
      .s_ready (req_ready[i]),
      .s_data  (req),
      .m_valid (m_req_valid[i]),
      .m_ready (m_req_ready[i]),
      .m_data  (m_req[i]),
      .fill    ()
    );
  end

  // Region and beat count, in arrival order
  stream_fifo #(
    .WIDTH($bits(seq_entry_t)),
    .DEPTH(N_OUTSTANDING)
  ) seq_fifo (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (seq_in_valid),
    .s_ready (seq_in_ready),
    .s_data  (seq_in),
    .m_valid (seq_out_valid),
    .m_ready (seq_out_ready),
    .m_data  (seq_out),
    .fill    ()
  );

  // ------------------------------
  // Data path
  // ------------------------------

  tcp_rx_data_demux data_demux (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .seq_valid    (seq_out_valid),
    .seq_ready    (seq_out_ready),
    .seq          (seq_out),
    .s_data_valid (s_data_valid),
    .s_data_ready (s_data_ready),
    .s_data       (s_data),
    .m_data_valid (m_data_valid),
    .m_data_ready (m_data_ready),
    .m_data       (m_data),
    .wr_rdy       (wr_rdy)
  );

endmodule

`default_nettype wire

// File: verilog/tcp_rx_data_demux.sv
`default_nettype none

module tcp_rx_data_demux import tcp_rx_pkg::*; (
  input  logic                 aclk,
  input  logic                 aresetn,
  // Ordering queue head
  input  logic                 seq_valid,
  output logic                 seq_ready,
  input  seq_entry_t           seq,
  // Payload beats in
  input  logic                 s_data_valid,
  output logic                 s_data_ready,
  input  axis_beat_t           s_data,
  // Per-region data out
  output logic [N_REGIONS-1:0] m_data_valid,
  input  logic [N_REGIONS-1:0] m_data_ready,
  output axis_beat_t           m_data [N_REGIONS],
  // Fill below threshold
  output logic [N_REGIONS-1:0] wr_rdy
);

  demux_state_t         state_q;
  demux_state_t         state_d;
  region_t              vfid_q;
  region_t              vfid_d;
  beat_cnt_t            cnt_q;
  beat_cnt_t            cnt_d;
  logic                 beat_xfer;
  logic                 tr_done;
  logic [N_REGIONS-1:0] wr_valid;
  logic [N_REGIONS-1:0] wr_ready;
  axis_beat_t           wr_beat;
  fill_t                fill [N_REGIONS];

  // ------------------------------
  // Steering
  // ------------------------------

  // No region selected while idle
  assign s_data_ready = (state_q == ST_MUX) && wr_ready[vfid_q];
  assign beat_xfer    = s_data_valid && s_data_ready;
  // Last beat of current payload
  assign tr_done      = beat_xfer && (cnt_q == '0);

  // Input tlast is dropped, boundary comes from the count
  always_comb begin
    wr_beat       = s_data;
    wr_beat.tlast = (cnt_q == '0);
  end

  // Only the selected region sees valid
  for (genvar i = 0; i < N_REGIONS; i++) begin : g_wr_sel
    assign wr_valid[i] = (state_q == ST_MUX) && (vfid_q == region_t'(i)) && s_data_valid;
  end

  // ------------------------------
  // FSM
  // ------------------------------

  always_comb begin
    state_d   = state_q;
    vfid_d    = vfid_q;
    cnt_d     = cnt_q;
    seq_ready = 1'b0;

    case (state_q)
      ST_IDLE: begin
        // Load next payload, beats flow from next cycle
        if (seq_valid) begin
          seq_ready = 1'b1;
          vfid_d    = seq.vfid;
          cnt_d     = seq.last_idx;
          state_d   = ST_MUX;
        end
      end

      ST_MUX: begin
        if (tr_done) begin
          // Chain straight into next payload if queued
          if (seq_valid) begin
            seq_ready = 1'b1;
            vfid_d    = seq.vfid;
            cnt_d     = seq.last_idx;
          end else begin
            state_d = ST_IDLE;
          end
        end else if (beat_xfer) begin
          cnt_d = cnt_q - 1'b1;
        end
      end

      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= ST_IDLE;
      vfid_q  <= '0;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      vfid_q  <= vfid_d;
      cnt_q   <= cnt_d;
    end
  end

  // ------------------------------
  // Region data FIFOs
  // ------------------------------

  for (genvar i = 0; i < N_REGIONS; i++) begin : g_data_fifo
    stream_fifo #(
      .WIDTH($bits(axis_beat_t)),
      .DEPTH(DATA_DEPTH)
    ) data_fifo (
      .aclk    (aclk),
      .aresetn (aresetn),
      .s_valid (wr_valid[i]),
      .s_ready (wr_ready[i]),
      .s_data  (wr_beat),
      .m_valid (m_data_valid[i]),
      .m_ready (m_data_ready[i]),
      .m_data  (m_data[i]),
      .fill    (fill[i])
    );

    // Follows registered fill
    assign wr_rdy[i] = (fill[i] <= fill_t'(WR_THRS));
  end

endmodule

`default_nettype wire

// File: verilog/tcp_rx_meta_demux.sv
`default_nettype none

module tcp_rx_meta_demux import tcp_rx_pkg::*; (
  // Incoming metadata
  input  logic                 s_meta_valid,
  output logic                 s_meta_ready,
  input  rx_meta_t             s_meta,
  // Per-region request queues
  output logic [N_REGIONS-1:0] req_valid,
  input  logic [N_REGIONS-1:0] req_ready,
  output rx_req_t              req,
  // Ordering queue
  output logic                 seq_valid,
  input  logic                 seq_ready,
  output seq_entry_t           seq
);

  logic accept;
  len_t len_m1;

  // ------------------------------
  // Handshake
  // ------------------------------

  // Both the ordering queue and the target region must have room
  assign s_meta_ready = seq_ready && req_ready[s_meta.vfid];
  assign accept       = s_meta_valid && s_meta_ready;

  // One write into each queue per accepted entry
  assign seq_valid = accept;

  for (genvar i = 0; i < N_REGIONS; i++) begin : g_req_sel
    assign req_valid[i] = accept && (s_meta.vfid == region_t'(i));
  end

  // ------------------------------
  // Payloads
  // ------------------------------

  // Same request fans out to all queues
  assign req.pid  = s_meta.pid;
  assign req.dest = s_meta.dest;
  assign req.len  = s_meta.len;

  // ceil(len/8)-1 is (len-1)/8
  // len is never zero, so no underflow
  assign len_m1 = s_meta.len - 1'b1;

  assign seq.vfid     = s_meta.vfid;
  assign seq.last_idx = len_m1[LEN_BITS-1:BEAT_LOG_BITS];

endmodule

`default_nettype wire

// File: verilog/tcp_rx_pkg.sv
`default_nettype none

package tcp_rx_pkg;

  // ------------------------------
  // Sizing
  // ------------------------------

  // Region count and id width
  localparam int N_REGIONS     = 4;
  localparam int REGION_BITS   = 2;

  // Payload length in bytes
  localparam int LEN_BITS      = 16;

  // Beat width, 8 bytes per beat
  localparam int DATA_BITS     = 64;
  localparam int BEAT_LOG_BITS = 3;

  // Queue depths
  localparam int N_OUTSTANDING = 8;
  localparam int META_DEPTH    = 4;
  localparam int DATA_DEPTH    = 32;

  // Fill counter, must hold DATA_DEPTH itself
  localparam int FILL_BITS     = 6;

  // Region may accept new writes at or below this fill
  localparam int WR_THRS       = 24;

  // ------------------------------
  // Scalar types
  // ------------------------------

  typedef logic [REGION_BITS-1:0]            region_t;
  typedef logic [LEN_BITS-1:0]               len_t;
  // Beats remaining minus one
  typedef logic [LEN_BITS-BEAT_LOG_BITS-1:0] beat_cnt_t;
  typedef logic [FILL_BITS-1:0]              fill_t;

  // ------------------------------
  // Stream payloads
  // ------------------------------

  // Receive metadata, one per payload
  typedef struct packed {
    region_t    vfid;
    logic [5:0] pid;
    logic [3:0] dest;
    len_t       len;
  } rx_meta_t;

  // Request handed to a region, vfid implied by the port
  typedef struct packed {
    logic [5:0] pid;
    logic [3:0] dest;
    len_t       len;
  } rx_req_t;

  // Ordering queue entry
  typedef struct packed {
    region_t   vfid;
    beat_cnt_t last_idx;
  } seq_entry_t;

  // Payload beat
  typedef struct packed {
    logic [DATA_BITS-1:0]   tdata;
    logic [DATA_BITS/8-1:0] tkeep;
    logic                   tlast;
  } axis_beat_t;

  // Data steering FSM
  typedef enum logic [0:0] {
    ST_IDLE,
    ST_MUX
  } demux_state_t;

endpackage

`default_nettype wire
